// ==== design/bcp_pkg.sv ====
package bcp_pkg;

	typedef enum logic [1:0]
	{
		LIT_NONE = 2'b00,
		LIT_POS  = 2'b01,
		LIT_NEG  = 2'b10
	} lit_t;

	typedef enum logic [1:0]
	{
		VAL_FREE  = 2'b00,
		VAL_TRUE  = 2'b01,
		VAL_FALSE = 2'b10
	} val_t;

	typedef logic [1:0] cnt_t;

	localparam cnt_t CNT_ZERO = 2'd0;
	localparam cnt_t CNT_ONE  = 2'd1;
	localparam cnt_t CNT_MANY = 2'd2; // two or more

	function automatic logic lit_sat(lit_t lit, val_t val);
		return ((lit == LIT_POS) && (val == VAL_TRUE)) ||
			((lit == LIT_NEG) && (val == VAL_FALSE));
	endfunction

	function automatic logic lit_free(lit_t lit, val_t val);
		return (lit != LIT_NONE) && (val == VAL_FREE);
	endfunction

	function automatic cnt_t cnt_add(cnt_t cnt);
		return (cnt == CNT_MANY) ? CNT_MANY : cnt + 2'd1; // saturate
	endfunction

endpackage

// ==== design/term_if.sv ====
`timescale 1ns/1ns

interface term_if
	import bcp_pkg::*;
#(
	parameter int NUM_VARS = 8
);

	logic sat; // any literal true
	cnt_t cnt; // free literals, saturated
	logic imp;
	logic conf;
	val_t [NUM_VARS-1:0] imp_vals;

	modport chain_mp
	(
		output sat,
		output cnt,
		input  imp,
		input  conf,
		input  imp_vals
	);

	modport term_mp
	(
		input  sat,
		input  cnt,
		output imp,
		output conf,
		output imp_vals
	);

endinterface

// ==== design/clause_cell.sv ====
`timescale 1ns/1ns

module clause_cell
	import bcp_pkg::*;
#(
	parameter int IDX = 0
)
(
	input  logic clk,
	input  logic rst,

	input  logic load_i,
	input  lit_t lit_i,
	input  val_t val_i,

	input  cnt_t cnt_pre_i,
	output cnt_t cnt_next_o,

	output logic sat_o,
	output val_t imp_val_o
);

	lit_t lit_r;
	cnt_t cnt_in;
	logic free_w;

	always_ff @(posedge clk)
	begin
		if (rst)
			lit_r <= LIT_NONE;
		else if (load_i)
			lit_r <= lit_i;
	end

	assign cnt_in = (IDX == 0) ? CNT_ZERO : cnt_pre_i; // head of chain counts from zero

	assign free_w = lit_free(lit_r, val_i);
	assign sat_o = lit_sat(lit_r, val_i);
	assign cnt_next_o = free_w ? cnt_add(cnt_in) : cnt_in;

	// value that would make this literal true
	always_comb
	begin
		if (!free_w)
			imp_val_o = VAL_FREE;
		else if (lit_r == LIT_POS)
			imp_val_o = VAL_TRUE;
		else
			imp_val_o = VAL_FALSE;
	end

endmodule

// ==== design/terminal_cell.sv ====
`timescale 1ns/1ns

module terminal_cell
	import bcp_pkg::*;
#(
	parameter int NUM_VARS = 8
)
(
	input  logic clk,
	input  logic rst,

	input  logic eval_i,
	term_if.term_mp tif,
	input  val_t [NUM_VARS-1:0] cell_vals_i
);

	logic imp_w;
	logic conf_w;

	assign imp_w = eval_i && !tif.sat && (tif.cnt == CNT_ONE); // unit clause
	assign conf_w = eval_i && !tif.sat && (tif.cnt == CNT_ZERO); // all literals false

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tif.imp <= 1'b0;
			tif.conf <= 1'b0;
		end
		else
		begin
			tif.imp <= imp_w;
			tif.conf <= conf_w;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int v = 0; v < NUM_VARS; v++)
		begin
			if (imp_w)
				tif.imp_vals[v] <= cell_vals_i[v];
			else
				tif.imp_vals[v] <= VAL_FREE;
		end
	end

	a_imp_conf_excl : assert property (@(posedge clk) disable iff (rst)
		!(tif.imp && tif.conf));

endmodule

// ==== design/clause.sv ====
`timescale 1ns/1ns

module clause
	import bcp_pkg::*;
#(
	parameter int NUM_VARS = 8
)
(
	input  logic clk,
	input  logic rst,

	input  logic load_i,
	input  lit_t [NUM_VARS-1:0] lits_i,

	input  logic eval_i,
	input  val_t [NUM_VARS-1:0] assign_i,
	input  logic backtrack_i,

	output logic imp_o,
	output logic conf_o,
	output val_t [NUM_VARS-1:0] imp_vals_o,
	output logic reason_o
);

	term_if #(.NUM_VARS(NUM_VARS)) tif ();

	logic [NUM_VARS-1:0] sat_vec;
	val_t [NUM_VARS-1:0] cell_vals;
	logic [NUM_VARS-1:0] set_vec;
	logic hold_r;

	for (genvar i = 0; i < NUM_VARS; i++)
	begin : g_cell
		cnt_t cnt_nx;

		clause_cell #(
			.IDX(i)
		) u_cell (
			.clk(clk),
			.rst(rst),
			.load_i(load_i),
			.lit_i(lits_i[i]),
			.val_i(assign_i[i]),
			.cnt_pre_i(g_cell[(i == 0) ? 0 : i - 1].cnt_nx), // cell 0 ignores it
			.cnt_next_o(cnt_nx),
			.sat_o(sat_vec[i]),
			.imp_val_o(cell_vals[i])
		);
	end

	assign tif.sat = |sat_vec;
	assign tif.cnt = g_cell[NUM_VARS-1].cnt_nx;

	terminal_cell #(
		.NUM_VARS(NUM_VARS)
	) u_term (
		.clk(clk),
		.rst(rst),
		.eval_i(eval_i),
		.tif(tif),
		.cell_vals_i(cell_vals)
	);

	assign imp_o = tif.imp;
	assign conf_o = tif.conf;
	assign imp_vals_o = tif.imp_vals;

	// set shows up with imp itself, so a same-edge backtrack loses
	always_ff @(posedge clk)
	begin
		if (rst)
			hold_r <= 1'b0;
		else
			hold_r <= reason_o && !backtrack_i;
	end

	assign reason_o = tif.imp | hold_r;

	always_comb
	begin
		for (int v = 0; v < NUM_VARS; v++)
			set_vec[v] = (imp_vals_o[v] != VAL_FREE);
	end

	// exactly one cell stays free in a unit clause
	a_one_implied : assert property (@(posedge clk) disable iff (rst)
		imp_o |-> $onehot(set_vec));

endmodule

// ==== design/imply_arbiter.sv ====
`timescale 1ns/1ns

module imply_arbiter
	import bcp_pkg::*;
#(
	parameter int NUM_VARS = 8,
	parameter int NUM_CLAUSES = 4,
	localparam int CW = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1,
	localparam int VW = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1
)
(
	input  logic clk,
	input  logic rst,

	input  logic eval_d_i,
	input  logic [NUM_CLAUSES-1:0] imp_i,
	input  logic [NUM_CLAUSES-1:0] conf_i,
	input  val_t [NUM_VARS-1:0] imp_vals_i [NUM_CLAUSES],

	output logic res_valid_o,
	output logic conf_o,
	output logic imp_o,
	output logic [CW-1:0] clause_idx_o,
	output logic [VW-1:0] var_idx_o,
	output val_t var_val_o
);

	logic conf_hit;
	logic imp_hit;
	logic [CW-1:0] cl_sel;
	logic [VW-1:0] var_sel;
	val_t val_sel;

	always_comb
	begin
		conf_hit = |conf_i;
		imp_hit = !conf_hit && (|imp_i); // any conflict beats implications
		cl_sel = '0;
		for (int c = NUM_CLAUSES - 1; c >= 0; c--)
		begin
			if (conf_hit ? conf_i[c] : imp_i[c])
				cl_sel = CW'(c); // lowest index last
		end
		var_sel = '0;
		val_sel = VAL_FREE;
		if (imp_hit)
		begin
			for (int v = NUM_VARS - 1; v >= 0; v--)
			begin
				if (imp_vals_i[cl_sel][v] != VAL_FREE)
				begin
					var_sel = VW'(v);
					val_sel = imp_vals_i[cl_sel][v];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res_valid_o <= 1'b0;
			conf_o <= 1'b0;
			imp_o <= 1'b0;
		end
		else
		begin
			res_valid_o <= eval_d_i;
			conf_o <= eval_d_i && conf_hit;
			imp_o <= eval_d_i && imp_hit;
		end
	end

	always_ff @(posedge clk)
	begin
		clause_idx_o <= cl_sel;
		var_idx_o <= var_sel;
		var_val_o <= val_sel;
	end

	a_result_excl : assert property (@(posedge clk) disable iff (rst)
		!(conf_o && imp_o));

endmodule

// ==== design/bcp_top.sv ====
`timescale 1ns/1ns

module bcp_top
	import bcp_pkg::*;
#(
	parameter int NUM_VARS = 8,
	parameter int NUM_CLAUSES = 4,
	localparam int CW = (NUM_CLAUSES > 1) ? $clog2(NUM_CLAUSES) : 1,
	localparam int VW = (NUM_VARS > 1) ? $clog2(NUM_VARS) : 1
)
(
	input  logic clk,
	input  logic rst,

	input  logic load_i,
	input  logic [CW-1:0] load_clause_i,
	input  lit_t [NUM_VARS-1:0] load_lits_i,

	input  logic eval_i,
	input  val_t [NUM_VARS-1:0] assign_i,
	input  logic backtrack_i,

	output logic res_valid_o,
	output logic conf_o,
	output logic imp_o,
	output logic [CW-1:0] clause_idx_o,
	output logic [VW-1:0] var_idx_o,
	output val_t var_val_o,
	output logic [NUM_CLAUSES-1:0] reason_o
);

	logic eval_d; // lines up with the terminal cell registers
	logic [NUM_CLAUSES-1:0] imp_w;
	logic [NUM_CLAUSES-1:0] conf_w;
	val_t [NUM_VARS-1:0] imp_vals_w [NUM_CLAUSES];

	always_ff @(posedge clk)
	begin
		if (rst)
			eval_d <= 1'b0;
		else
			eval_d <= eval_i;
	end

	for (genvar c = 0; c < NUM_CLAUSES; c++)
	begin : g_clause
		clause #(
			.NUM_VARS(NUM_VARS)
		) u_clause (
			.clk(clk),
			.rst(rst),
			.load_i(load_i && (load_clause_i == CW'(c))),
			.lits_i(load_lits_i),
			.eval_i(eval_i),
			.assign_i(assign_i),
			.backtrack_i(backtrack_i),
			.imp_o(imp_w[c]),
			.conf_o(conf_w[c]),
			.imp_vals_o(imp_vals_w[c]),
			.reason_o(reason_o[c])
		);
	end

	imply_arbiter #(
		.NUM_VARS(NUM_VARS),
		.NUM_CLAUSES(NUM_CLAUSES)
	) u_arb (
		.clk(clk),
		.rst(rst),
		.eval_d_i(eval_d),
		.imp_i(imp_w),
		.conf_i(conf_w),
		.imp_vals_i(imp_vals_w),
		.res_valid_o(res_valid_o),
		.conf_o(conf_o),
		.imp_o(imp_o),
		.clause_idx_o(clause_idx_o),
		.var_idx_o(var_idx_o),
		.var_val_o(var_val_o)
	);

endmodule

// ==== dv/bcp_ref.svh ====
`ifndef BCP_REF_SVH
`define BCP_REF_SVH

typedef lit_t [NV-1:0] lits_t;
typedef val_t [NV-1:0] asg_t;

typedef struct packed
{
	logic conf;
	logic imp;
	int cl;
	int vr;
	val_t vl;
	int due; // cycle the result must show up in
} res_t;

// 0 satisfied or open, 1 unit, 2 conflict
function automatic int clause_state(lits_t lits, asg_t asg, output int vr, output val_t vl);
	int nfree;
	logic sat;
	nfree = 0;
	sat = 1'b0;
	vr = 0;
	vl = VAL_FREE;
	for (int v = 0; v < NV; v++)
	begin
		if (lits[v] != LIT_NONE)
		begin
			if (asg[v] == VAL_FREE)
			begin
				nfree++;
				vr = v;
				if (lits[v] == LIT_POS)
					vl = VAL_TRUE;
				else
					vl = VAL_FALSE;
			end
			else if ((lits[v] == LIT_POS) == (asg[v] == VAL_TRUE))
				sat = 1'b1;
		end
	end
	if (sat || nfree > 1)
		return 0;
	return (nfree == 1) ? 1 : 2;
endfunction

// conflicts beat implications, lowest clause first in each class
function automatic res_t ref_result(lits_t lits [NC], asg_t asg);
	res_t r;
	int st;
	int vr;
	val_t vl;
	r = '0;
	r.vl = VAL_FREE;
	for (int c = 0; c < NC; c++)
	begin
		st = clause_state(lits[c], asg, vr, vl);
		if (st == 2 && !r.conf)
		begin
			r.conf = 1'b1;
			r.imp = 1'b0;
			r.cl = c;
			r.vr = 0;
			r.vl = VAL_FREE;
		end
		else if (st == 1 && !r.conf && !r.imp)
		begin
			r.imp = 1'b1;
			r.cl = c;
			r.vr = vr;
			r.vl = vl;
		end
	end
	return r;
endfunction

`endif

// ==== dv/tb_bcp.sv ====
`timescale 1ns/1ns

module tb_bcp
	import bcp_pkg::*;
();

	localparam int NV = 8;
	localparam int NC = 4;

	`include "bcp_ref.svh"

	logic clk;
	logic rst;
	logic load_i;
	logic [1:0] load_clause_i;
	lits_t load_lits_i;
	logic eval_i;
	asg_t assign_i;
	logic backtrack_i;
	logic res_valid_o;
	logic conf_o;
	logic imp_o;
	logic [1:0] clause_idx_o;
	logic [2:0] var_idx_o;
	val_t var_val_o;
	logic [NC-1:0] reason_o;

	lits_t lits_sh [NC]; // literals as the DUT holds them
	logic [NC-1:0] reason_exp;
	res_t exp_q [$];
	int cyc;
	int errors = 0;
	int checks = 0;

	bcp_top #(
		.NUM_VARS(NV),
		.NUM_CLAUSES(NC)
	) u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic lits_t lits_from(logic [NV-1:0] pos, logic [NV-1:0] neg);
		lits_t l;
		for (int v = 0; v < NV; v++)
		begin
			if (pos[v])
				l[v] = LIT_POS;
			else if (neg[v])
				l[v] = LIT_NEG;
			else
				l[v] = LIT_NONE;
		end
		return l;
	endfunction

	function automatic asg_t asg_from(logic [NV-1:0] tru, logic [NV-1:0] fal);
		asg_t a;
		for (int v = 0; v < NV; v++)
		begin
			if (tru[v])
				a[v] = VAL_TRUE;
			else if (fal[v])
				a[v] = VAL_FALSE;
			else
				a[v] = VAL_FREE;
		end
		return a;
	endfunction

	function automatic lits_t rand_lits();
		lits_t l;
		for (int v = 0; v < NV; v++)
		begin
			case ($urandom_range(0, 3))
				1: l[v] = LIT_POS;
				2: l[v] = LIT_NEG;
				default: l[v] = LIT_NONE; // half the slots empty
			endcase
		end
		return l;
	endfunction

	function automatic asg_t rand_asg();
		asg_t a;
		for (int v = 0; v < NV; v++)
		begin
			case ($urandom_range(0, 2))
				1: a[v] = VAL_TRUE;
				2: a[v] = VAL_FALSE;
				default: a[v] = VAL_FREE;
			endcase
		end
		return a;
	endfunction

	task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic drive(logic ld, int lc, lits_t ll, logic ev, asg_t a, logic bt);
		@(negedge clk);
		load_i = ld;
		load_clause_i = 2'(lc);
		load_lits_i = ll;
		eval_i = ev;
		assign_i = a;
		backtrack_i = bt;
	endtask

	task automatic load_clause(int c, lits_t l);
		drive(1'b1, c, l, 1'b0, asg_from(8'h00, 8'h00), 1'b0);
	endtask

	task automatic eval_asg(asg_t a, logic bt);
		drive(1'b0, 0, lits_from(8'h00, 8'h00), 1'b1, a, bt);
	endtask

	task automatic wait_results();
		int t;
		t = 0;
		while (exp_q.size() > 0 && t < 20)
		begin
			@(negedge clk);
			t++;
		end
		if (exp_q.size() > 0)
		begin
			$display("timeout waiting for res_valid_o, %0d results never came", exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic finish_test(string name, int mark);
		drive(1'b0, 0, lits_from(8'h00, 8'h00), 1'b0, asg_from(8'h00, 8'h00), 1'b0);
		wait_results();
		$display("test %s: %0d errors", name, errors - mark);
	endtask

	// scoreboard and shadow state
	always @(posedge clk)
	begin
		res_t r;
		int st;
		int vr;
		val_t vl;
		logic [NC-1:0] rs_nx;
		if (rst)
		begin
			cyc = 0;
			reason_exp = '0;
			exp_q.delete();
			for (int c = 0; c < NC; c++)
				lits_sh[c] = lits_from(8'h00, 8'h00);
		end
		else
		begin
			cyc++;
			if (reason_o !== reason_exp)
			begin
				$display("error %0t: reason_o is %b, expected %b", $time, reason_o, reason_exp);
				errors++;
			end
			if (res_valid_o)
			begin
				if (exp_q.size() == 0)
				begin
					$display("error %0t: res_valid_o with no eval pending", $time);
					errors++;
				end
				else
				begin
					r = exp_q.pop_front();
					checks++;
					check_field("result cycle", cyc, r.due);
					check_field("conf_o", 32'(conf_o), 32'(r.conf));
					check_field("imp_o", 32'(imp_o), 32'(r.imp));
					check_field("clause_idx_o", 32'(clause_idx_o), r.cl);
					check_field("var_idx_o", 32'(var_idx_o), r.vr);
					check_field("var_val_o", 32'(var_val_o), 32'(r.vl));
				end
			end
			else if (exp_q.size() > 0 && exp_q[0].due <= cyc)
			begin
				$display("error %0t: result of eval in cycle %0d missing", $time, exp_q[0].due - 2);
				errors++;
				void'(exp_q.pop_front());
			end
			if (eval_i)
			begin
				r = ref_result(lits_sh, assign_i);
				r.due = cyc + 2;
				exp_q.push_back(r);
			end
			for (int c = 0; c < NC; c++)
			begin
				st = clause_state(lits_sh[c], assign_i, vr, vl);
				rs_nx[c] = (eval_i && st == 1) || (reason_exp[c] && !backtrack_i); // set wins
			end
			reason_exp = rs_nx;
			if (load_i)
				lits_sh[load_clause_i] = load_lits_i; // same-cycle eval saw old literals
		end
	end

	initial
	begin
		int mark;
		void'($urandom(32'h2972536f));
		rst = 1'b1;
		load_i = 1'b0;
		load_clause_i = 2'd0;
		load_lits_i = lits_from(8'h00, 8'h00);
		eval_i = 1'b0;
		assign_i = asg_from(8'h00, 8'h00);
		backtrack_i = 1'b0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		load_clause(0, lits_from(8'h05, 8'h02));
		load_clause(1, lits_from(8'h0a, 8'h10));
		load_clause(2, lits_from(8'h40, 8'h20));
		load_clause(3, lits_from(8'h80, 8'h05));

		mark = errors;
		eval_asg(asg_from(8'h00, 8'h00), 1'b0);
		eval_asg(asg_from(8'h03, 8'h20), 1'b0);
		finish_test("satisfied and open clauses", mark);

		mark = errors;
		eval_asg(asg_from(8'h02, 8'h01), 1'b0); // clause 0 forces x2 true
		eval_asg(asg_from(8'h01, 8'h42), 1'b0); // clause 2 forces x5 false
		eval_asg(asg_from(8'h01, 8'h80), 1'b0);
		finish_test("unit implication", mark);

		mark = errors;
		eval_asg(asg_from(8'h05, 8'hca), 1'b0);
		eval_asg(asg_from(8'h15, 8'hca), 1'b0); // clauses 1 and 3 conflict
		eval_asg(asg_from(8'h01, 8'hca), 1'b0);
		finish_test("conflict priority", mark);

		mark = errors;
		drive(1'b0, 0, lits_from(8'h00, 8'h00), 1'b0, asg_from(8'h00, 8'h00), 1'b1);
		eval_asg(asg_from(8'h02, 8'h01), 1'b0);
		eval_asg(asg_from(8'h00, 8'h00), 1'b0);
		eval_asg(asg_from(8'h03, 8'h20), 1'b0);
		eval_asg(asg_from(8'h01, 8'h42), 1'b1); // set and clear on one edge
		eval_asg(asg_from(8'h00, 8'h00), 1'b0);
		drive(1'b0, 0, lits_from(8'h00, 8'h00), 1'b0, asg_from(8'h00, 8'h00), 1'b1);
		finish_test("reason flags", mark);

		mark = errors;
		for (int i = 0; i < 300; i++)
		begin
			if ($urandom_range(0, 4) == 0)
				load_clause($urandom_range(0, NC - 1), rand_lits());
			drive($urandom_range(0, 5) == 0, $urandom_range(0, NC - 1), rand_lits(), 1'b1,
				rand_asg(), $urandom_range(0, 7) == 0);
		end
		finish_test("back-to-back random evals", mark);

		$display("%0d results checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+dv
design/bcp_pkg.sv
design/term_if.sv
design/clause_cell.sv
design/terminal_cell.sv
design/clause.sv
design/imply_arbiter.sv
design/bcp_top.sv
dv/tb_bcp.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the BCP engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_bcp -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_bcp)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
